//--- src.f
hdl/dcache_pkg.sv
hdl/tag_lookup_if.sv
hdl/data_access_if.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/tb_mem_model.sv
verification/tb_dcache.sv

//--- Makefile
# Verilator build for the data cache testbench
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST) 2>/dev/null)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exit status carries pass or fail
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int random_ops        = 400;
    localparam int directed_ops      = 16;
    localparam int worst_miss_cycles = 40;   // write-back and fetch both fully stalled
    localparam int cycle_limit       = (random_ops + directed_ops) * worst_miss_cycles + 200;

    logic                                clock = 1'b0;
    logic                                reset_n;
    logic                                req_valid;
    logic                                req_write;
    logic [dcache_pkg::addr_width-1:0]   req_addr;
    logic [dcache_pkg::word_width-1:0]   req_wdata;
    logic [dcache_pkg::word_width-1:0]   req_wmask;
    logic                                req_ready;
    logic                                resp_done;
    logic [dcache_pkg::word_width-1:0]   resp_rdata;
    logic                                mem_req_valid;
    logic                                mem_req_write;
    logic [dcache_pkg::addr_width-1:0]   mem_req_addr;
    logic [dcache_pkg::line_width-1:0]   mem_req_line;
    logic                                mem_req_ready;
    logic                                mem_done;
    logic [dcache_pkg::line_width-1:0]   mem_rdata_line;
    int                                  write_count;
    dcache_pkg::addr_t                   last_write_addr;
    dcache_pkg::line_t                   last_write_line;

    dcache_pkg::word_t ref_mem [dcache_pkg::addr_t];   // keyed by word address
    dcache_pkg::word_t expected_q [$];
    logic [15:0]       lfsr_state = 16'd15301;
    int                checked = 0;
    int                accepted = 0;
    int                cycles = 0;
    int                mem_requests = 0;

    always #5 clock = ~clock;

    dcache_top dut (.*);
    tb_mem_model mem_model (.*);

    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 16'hB400;
        return out;
    endfunction

    function automatic logic [63:0] random_bits(int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) value = {value[62:0], lfsr_bit()};
        return value;
    endfunction

    function automatic dcache_pkg::word_t pattern_word(dcache_pkg::addr_t addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:3], 3'b000};
        return {~word_addr, word_addr} ^ 64'h5a5a_0000_0000_a5a5;
    endfunction

    // flat memory model that returns the read word or zero for a write
    function automatic dcache_pkg::word_t ref_access(logic write, dcache_pkg::addr_t addr,
                                                     dcache_pkg::word_t wdata,
                                                     dcache_pkg::word_t wmask);
        dcache_pkg::addr_t word_addr;
        dcache_pkg::word_t old_word;
        word_addr = {addr[31:3], 3'b000};
        old_word  = ref_mem.exists(word_addr) ? ref_mem[word_addr] : pattern_word(word_addr);
        if (write) begin
            ref_mem[word_addr] = (wdata & wmask) | (old_word & ~wmask);
            return '0;
        end
        return old_word;
    endfunction

    function automatic dcache_pkg::addr_t make_addr(dcache_pkg::tag_t tag,
                                                    dcache_pkg::index_t index,
                                                    dcache_pkg::bank_t bank);
        return {tag, index, bank, 3'b000};
    endfunction

    task automatic check_value(string what, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // issues one request and waits for resp_done
    task automatic run_op(input logic write, input dcache_pkg::addr_t addr,
                          input dcache_pkg::word_t wdata, input dcache_pkg::word_t wmask,
                          output int latency);
        expected_q.push_back(ref_access(write, addr, wdata, wmask));
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_wmask = wmask;
        while (!req_ready) next_cycle();
        next_cycle();
        req_valid = 1'b0;
        accepted++;
        latency   = 1;   // counted from the accepting edge
        while (!resp_done) begin
            next_cycle();
            latency++;
        end
    endtask

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // responses sampled mid-cycle
    always @(negedge clock) begin
        if (mem_req_valid && mem_req_ready) mem_requests++;
        if (reset_n && resp_done) begin
            check_value("response with no request pending",
                        64'(checked >= accepted), 64'd0);
            check_value("read data", resp_rdata, expected_q[checked]);
            checked++;
        end
    end

    initial begin
        int                latency;
        int                reqs_before;
        int                wb_before;
        logic              op_write;
        dcache_pkg::addr_t op_addr;
        dcache_pkg::word_t op_data;
        dcache_pkg::word_t op_mask;
        dcache_pkg::addr_t a;
        dcache_pkg::addr_t b;
        dcache_pkg::addr_t c;
        reset_n   = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        repeat (10) @(posedge clock);
        #1 reset_n = 1'b1;
        next_cycle();
        check_value("req_ready after reset", 64'(req_ready), 64'd1);
        check_value("resp_done after reset", 64'(resp_done), 64'd0);
        check_value("mem_req_valid after reset", 64'(mem_req_valid), 64'd0);

        // read miss and then a hit on the same word
        a = make_addr(17'h00010, 9'd5, 3'd2);
        run_op(1'b0, a, '0, '0, latency);
        reqs_before = mem_requests;
        run_op(1'b0, a, '0, '0, latency);
        check_value("read hit latency", 64'(latency), 64'd3);
        check_value("memory requests during a hit", 64'(mem_requests), 64'(reqs_before));

        // partial write hit
        run_op(1'b1, a, 64'hdead_beef_0123_4567, 64'hffff_0000_00ff_ff00, latency);
        check_value("write hit latency", 64'(latency), 64'd2);
        run_op(1'b0, a, '0, '0, latency);

        b = make_addr(17'h00020, 9'd6, 3'd7);   // write miss
        run_op(1'b1, b, 64'h0123_4567_89ab_cdef, 64'h0000_ffff_ffff_0000, latency);
        run_op(1'b0, b, '0, '0, latency);

        // three dirty tags in one set
        a = make_addr(17'h00100, 9'd100, 3'd1);
        b = make_addr(17'h00101, 9'd100, 3'd1);
        c = make_addr(17'h00102, 9'd100, 3'd1);
        wb_before = write_count;
        run_op(1'b1, a, 64'h1111_2222_3333_4444, '1, latency);
        run_op(1'b1, b, 64'h5555_6666_7777_8888, '1, latency);
        run_op(1'b1, c, 64'h9999_aaaa_bbbb_cccc, 64'h0000_0000_ffff_ffff, latency);
        check_value("write-backs for the third tag", 64'(write_count - wb_before), 64'd1);
        for (int i = 0; i < dcache_pkg::bank_count; i++) begin
            check_value("written-back line", last_write_line[i],
                        ref_access(1'b0, last_write_addr + dcache_pkg::addr_t'(i * 8), '0, '0));
        end
        run_op(1'b0, a, '0, '0, latency);
        run_op(1'b0, b, '0, '0, latency);

        // few tags over four sets so that hits and evictions mix
        repeat (random_ops) begin
            op_write = 1'(random_bits(1));
            op_addr  = make_addr(17'h00200 + dcache_pkg::tag_t'(random_bits(2)),
                                 9'd200 + dcache_pkg::index_t'(random_bits(2)),
                                 dcache_pkg::bank_t'(random_bits(3)));
            op_data  = random_bits(64);
            op_mask  = random_bits(64);
            run_op(op_write, op_addr, op_data, op_mask, latency);
        end

        while (checked != expected_q.size()) next_cycle();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- verification/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                mem_req_valid,
    input  logic                                mem_req_write,
    input  logic [dcache_pkg::addr_width-1:0]   mem_req_addr,
    input  logic [dcache_pkg::line_width-1:0]   mem_req_line,
    output logic                                mem_req_ready,
    output logic                                mem_done,
    output logic [dcache_pkg::line_width-1:0]   mem_rdata_line,
    output int                                  write_count,
    output dcache_pkg::addr_t                   last_write_addr,
    output dcache_pkg::line_t                   last_write_line
);

    dcache_pkg::line_t lines [dcache_pkg::addr_t];   // sparse store, keyed by line address
    logic [15:0]       lfsr_state = 16'd15301;

    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 16'hB400;
        return out;
    endfunction

    // 0 to 3 cycles
    function automatic int stall_cycles();
        int count;
        count = 0;
        repeat (2) count = (count << 1) | int'(lfsr_bit());
        return count;
    endfunction

    function automatic dcache_pkg::word_t pattern_word(dcache_pkg::addr_t addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:3], 3'b000};
        return {~word_addr, word_addr} ^ 64'h5a5a_0000_0000_a5a5;
    endfunction

    // first touch preloads the pattern
    function automatic dcache_pkg::line_t line_for(dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t fresh;
        if (!lines.exists(line_addr)) begin
            for (int b = 0; b < dcache_pkg::bank_count; b++) begin
                fresh[b] = pattern_word(line_addr + dcache_pkg::addr_t'(b * 8));
            end
            lines[line_addr] = fresh;
        end
        return lines[line_addr];
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic serve_request();
        dcache_pkg::addr_t addr;
        dcache_pkg::line_t line;
        logic              write;
        addr  = mem_req_addr;   // stable while valid is held
        line  = mem_req_line;
        write = mem_req_write;
        repeat (stall_cycles()) next_cycle();
        mem_req_ready = 1'b1;
        next_cycle();           // handshake on this edge
        mem_req_ready = 1'b0;
        repeat (stall_cycles()) next_cycle();
        if (write) begin
            lines[addr]     = line;
            write_count++;
            last_write_addr = addr;
            last_write_line = lines[addr];
        end else begin
            mem_rdata_line = line_for(addr);
        end
        mem_done = 1'b1;
        next_cycle();
        mem_done = 1'b0;
    endtask

    initial begin
        mem_req_ready   = 1'b0;
        mem_done        = 1'b0;
        mem_rdata_line  = '0;
        write_count     = 0;
        last_write_addr = '0;
        last_write_line = '0;
        forever begin
            next_cycle();
            if (reset_n && mem_req_valid) serve_request();
        end
    end

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                                clock,
    input  logic                                reset_n,

    // core side
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [dcache_pkg::addr_width-1:0]   req_addr,
    input  logic [dcache_pkg::word_width-1:0]   req_wdata,
    input  logic [dcache_pkg::word_width-1:0]   req_wmask,
    output logic                                req_ready,
    output logic                                resp_done,
    output logic [dcache_pkg::word_width-1:0]   resp_rdata,

    // memory side, whole lines
    output logic                                mem_req_valid,
    output logic                                mem_req_write,
    output logic [dcache_pkg::addr_width-1:0]   mem_req_addr,
    output logic [dcache_pkg::line_width-1:0]   mem_req_line,
    input  logic                                mem_req_ready,
    input  logic                                mem_done,
    input  logic [dcache_pkg::line_width-1:0]   mem_rdata_line
);

    tag_lookup_if  tags_if ();
    data_access_if data_if ();

    dcache_tag_store u_tag_store (
        .clock   (clock),
        .reset_n (reset_n),
        .tags    (tags_if.slave)
    );

    dcache_data_store u_data_store (
        .clock (clock),
        .data  (data_if.slave)
    );

    dcache_ctrl u_ctrl (
        .clock          (clock),
        .reset_n        (reset_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_wmask      (req_wmask),
        .req_ready      (req_ready),
        .resp_done      (resp_done),
        .resp_rdata     (resp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_write  (mem_req_write),
        .mem_req_addr   (mem_req_addr),
        .mem_req_line   (mem_req_line),
        .mem_req_ready  (mem_req_ready),
        .mem_done       (mem_done),
        .mem_rdata_line (mem_rdata_line),
        .tags           (tags_if.master),
        .data           (data_if.master)
    );

endmodule

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                clock,
    input  logic                reset_n,

    input  logic                req_valid,
    input  logic                req_write,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::word_t   req_wmask,
    output logic                req_ready,
    output logic                resp_done,
    output dcache_pkg::word_t   resp_rdata,

    output logic                mem_req_valid,
    output logic                mem_req_write,
    output dcache_pkg::addr_t   mem_req_addr,
    output dcache_pkg::line_t   mem_req_line,
    input  logic                mem_req_ready,
    input  logic                mem_done,
    input  dcache_pkg::line_t   mem_rdata_line,

    tag_lookup_if.master        tags,
    data_access_if.master       data
);

    dcache_pkg::ctrl_state_t state, next_state;

    dcache_pkg::addr_t  addr_q;
    logic               write_q;
    dcache_pkg::word_t  wdata_q;
    dcache_pkg::word_t  wmask_q;
    dcache_pkg::line_t  fill_q;      // fetched line, already merged on writes

    dcache_pkg::tag_t   tag_q;
    dcache_pkg::index_t index_q;
    dcache_pkg::bank_t  bank_q;
    logic               accept;
    logic               start_fetch;

    assign tag_q   = addr_q[dcache_pkg::tag_lsb +: dcache_pkg::tag_bits];
    assign index_q = addr_q[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
    assign bank_q  = addr_q[dcache_pkg::bank_lsb +: dcache_pkg::bank_bits];

    assign req_ready = (state == dcache_pkg::idle);
    assign accept    = req_ready && req_valid;

    // clean miss goes straight to fetch, dirty miss after the write-back is done
    assign start_fetch = (state == dcache_pkg::lookup && !tags.hit && !tags.victim_dirty) ||
                         (state == dcache_pkg::write_back && mem_done);

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::idle: begin
                if (req_valid) next_state = dcache_pkg::lookup;
            end
            dcache_pkg::lookup: begin
                if (tags.hit) begin
                    next_state = write_q ? dcache_pkg::write_hit : dcache_pkg::read_hit;
                end else if (tags.victim_dirty) begin
                    next_state = dcache_pkg::read_victim;
                end else begin
                    next_state = dcache_pkg::fetch;
                end
            end
            dcache_pkg::read_victim: next_state = dcache_pkg::write_back;
            dcache_pkg::write_back: begin
                if (mem_done) next_state = dcache_pkg::fetch;
            end
            dcache_pkg::fetch: begin
                if (mem_done) next_state = dcache_pkg::refill;
            end
            default: next_state = dcache_pkg::idle;  // write_hit, read_hit, refill
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= dcache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req_addr;
            write_q <= req_write;
            wdata_q <= req_wdata;
            wmask_q <= req_wmask;
        end
    end

    // tag port, lookup uses the incoming address while idle
    always_comb begin
        tags.lookup       = accept;
        tags.index        = index_q;
        tags.tag          = tag_q;
        tags.update       = (state == dcache_pkg::write_hit) || (state == dcache_pkg::refill);
        tags.update_way   = tags.hit_way;
        tags.update_dirty = 1'b1;
        if (state == dcache_pkg::idle) begin
            tags.index = req_addr[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
            tags.tag   = req_addr[dcache_pkg::tag_lsb +: dcache_pkg::tag_bits];
        end
        if (state == dcache_pkg::refill) begin
            tags.update_way   = tags.victim_way;
            tags.update_dirty = write_q;   // write miss leaves the line dirty
        end
    end

    // data port
    always_comb begin
        data.read       = 1'b0;
        data.word_write = (state == dcache_pkg::write_hit);
        data.line_write = (state == dcache_pkg::refill);
        data.way        = tags.hit_way;
        data.index      = index_q;
        data.bank       = bank_q;
        data.wdata      = wdata_q;
        data.wmask      = wmask_q;
        data.line_in    = fill_q;
        if (state == dcache_pkg::lookup) begin
            if (tags.hit) begin
                data.read = !write_q;
            end else if (tags.victim_dirty) begin
                data.read = 1'b1;   // victim line for the write-back
                data.way  = tags.victim_way;
            end
        end
        if (state == dcache_pkg::refill) begin
            data.way = tags.victim_way;
        end
    end

    always_ff @(posedge clock) begin
        if (state == dcache_pkg::fetch && mem_done) begin
            for (int b = 0; b < dcache_pkg::bank_count; b++) begin
                if (write_q && (dcache_pkg::bank_t'(b) == bank_q)) begin
                    fill_q[b] <= dcache_pkg::merge_word(mem_rdata_line[b], wdata_q, wmask_q);
                end else begin
                    fill_q[b] <= mem_rdata_line[b];
                end
            end
        end
    end

    // memory bus request, held until accepted
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_req_valid <= 1'b0;
        end else if (state == dcache_pkg::read_victim || start_fetch) begin
            mem_req_valid <= 1'b1;
        end else if (mem_req_ready) begin
            mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (state == dcache_pkg::read_victim) begin
            mem_req_write <= 1'b1;
            mem_req_addr  <= {tags.victim_tag, index_q, {dcache_pkg::offset_bits{1'b0}}};
            mem_req_line  <= data.rdata_line;
        end else if (start_fetch) begin
            mem_req_write <= 1'b0;
            mem_req_addr  <= {tag_q, index_q, {dcache_pkg::offset_bits{1'b0}}};
        end
    end

    // core response, one cycle pulse
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            resp_done  <= 1'b0;
            resp_rdata <= '0;
        end else begin
            resp_done  <= 1'b0;
            resp_rdata <= '0;
            case (state)
                dcache_pkg::lookup: begin
                    resp_done <= tags.hit && write_q;   // high during write_hit
                end
                dcache_pkg::read_hit: begin
                    resp_done  <= 1'b1;
                    resp_rdata <= data.rdata_word;
                end
                dcache_pkg::refill: begin
                    resp_done <= 1'b1;
                    if (!write_q) resp_rdata <= fill_q[bank_q];
                end
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/dcache_data_store.sv
`timescale 1ns/1ps

module dcache_data_store (
    input logic          clock,
    data_access_if.slave data
);

    // way by set by bank
    dcache_pkg::word_t mem [dcache_pkg::way_count][dcache_pkg::set_count][dcache_pkg::bank_count];

    dcache_pkg::word_t old_word;

    assign old_word = mem[data.way][data.index][data.bank];

    // writes land at the strobe edge
    always_ff @(posedge clock) begin
        if (data.word_write) begin
            mem[data.way][data.index][data.bank] <=
                dcache_pkg::merge_word(old_word, data.wdata, data.wmask);
        end
        if (data.line_write) begin
            for (int b = 0; b < dcache_pkg::bank_count; b++) begin
                mem[data.way][data.index][b] <= data.line_in[b];
            end
        end
    end

    // word and whole line, both registered
    always_ff @(posedge clock) begin
        if (data.read) begin
            data.rdata_word <= old_word;
            for (int b = 0; b < dcache_pkg::bank_count; b++) begin
                data.rdata_line[b] <= mem[data.way][data.index][b];
            end
        end
    end

endmodule

//--- hdl/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store (
    input logic         clock,
    input logic         reset_n,
    tag_lookup_if.slave tags
);

    dcache_pkg::tag_t tag_mem [dcache_pkg::way_count][dcache_pkg::set_count];
    logic [dcache_pkg::set_count-1:0] valid_mem [dcache_pkg::way_count];
    logic [dcache_pkg::set_count-1:0] dirty_mem [dcache_pkg::way_count];

    logic [7:0]                       lfsr_q;
    logic [dcache_pkg::way_count-1:0] way_valid;
    logic [dcache_pkg::way_count-1:0] way_hit;
    dcache_pkg::way_t                 hit_way_c;
    dcache_pkg::way_t                 victim_c;

    // compare both ways of the addressed set
    always_comb begin
        hit_way_c = '0;
        victim_c  = dcache_pkg::way_t'(lfsr_q);   // random pick when the set is full
        for (int w = dcache_pkg::way_count - 1; w >= 0; w--) begin
            way_valid[w] = valid_mem[w][tags.index];
            way_hit[w]   = way_valid[w] && (tag_mem[w][tags.index] == tags.tag);
            if (way_hit[w]) begin
                hit_way_c = dcache_pkg::way_t'(w);
            end
            if (!way_valid[w]) begin
                victim_c = dcache_pkg::way_t'(w);  // lowest invalid way wins
            end
        end
    end

    // valid bits and lookup results
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int w = 0; w < dcache_pkg::way_count; w++) begin
                valid_mem[w] <= '0;
            end
            lfsr_q            <= dcache_pkg::lfsr_seed;
            tags.hit          <= 1'b0;
            tags.hit_way      <= '0;
            tags.victim_way   <= '0;
            tags.victim_dirty <= 1'b0;
        end else begin
            // x^8 + x^6 + x^5 + x^4 + 1
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            if (tags.update) begin
                valid_mem[tags.update_way][tags.index] <= 1'b1;
            end
            if (tags.lookup) begin
                tags.hit          <= |way_hit;
                tags.hit_way      <= hit_way_c;
                tags.victim_way   <= victim_c;
                tags.victim_dirty <= valid_mem[victim_c][tags.index] &&
                                     dirty_mem[victim_c][tags.index];
            end
        end
    end

    // tag and dirty arrays
    always_ff @(posedge clock) begin
        if (tags.update) begin
            tag_mem[tags.update_way][tags.index]   <= tags.tag;
            dirty_mem[tags.update_way][tags.index] <= tags.update_dirty;
        end
        if (tags.lookup) begin
            tags.victim_tag <= tag_mem[victim_c][tags.index];
        end
    end

endmodule

//--- hdl/data_access_if.sv
`timescale 1ns/1ps

interface data_access_if;

    logic                  read;
    logic                  word_write;
    logic                  line_write;
    dcache_pkg::way_t      way;
    dcache_pkg::index_t    index;
    dcache_pkg::bank_t     bank;
    dcache_pkg::word_t     wdata;
    dcache_pkg::word_t     wmask;
    dcache_pkg::line_t     line_in;

    // registered read data, one cycle after read
    dcache_pkg::word_t     rdata_word;
    dcache_pkg::line_t     rdata_line;

    modport master (
        output read, word_write, line_write, way, index, bank, wdata, wmask, line_in,
        input  rdata_word, rdata_line
    );

    modport slave (
        input  read, word_write, line_write, way, index, bank, wdata, wmask, line_in,
        output rdata_word, rdata_line
    );

endinterface

//--- hdl/tag_lookup_if.sv
`timescale 1ns/1ps

interface tag_lookup_if;

    logic                  lookup;
    dcache_pkg::index_t    index;
    dcache_pkg::tag_t      tag;
    logic                  update;
    dcache_pkg::way_t      update_way;
    logic                  update_dirty;

    // results, one cycle after lookup, held until the next lookup
    logic                  hit;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::way_t      victim_way;
    logic                  victim_dirty;
    dcache_pkg::tag_t      victim_tag;

    modport master (
        output lookup, index, tag, update, update_way, update_dirty,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport slave (
        input  lookup, index, tag, update, update_way, update_dirty,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

endinterface

//--- hdl/dcache_pkg.sv
package dcache_pkg;

    // sizes
    localparam int addr_width = 32;
    localparam int word_width = 64;
    localparam int bank_count = 8;
    localparam int way_count  = 2;
    localparam int set_count  = 512;
    localparam int line_width = word_width * bank_count;

    // address split: tag 31..15, index 14..6, bank 5..3
    localparam int offset_bits = 6;
    localparam int bank_bits   = 3;
    localparam int index_bits  = 9;
    localparam int tag_bits    = 17;
    localparam int bank_lsb    = offset_bits - bank_bits;
    localparam int tag_lsb     = offset_bits + index_bits;

    localparam logic [7:0] lfsr_seed = 8'hFF;

    typedef logic [word_width-1:0] word_t;
    typedef word_t [bank_count-1:0] line_t;   // bank 0 in the low 64 bits
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [bank_bits-1:0]  bank_t;
    typedef logic [$clog2(way_count)-1:0] way_t;

    typedef enum logic [2:0] {
        idle        = 3'd0,
        lookup      = 3'd1,
        write_hit   = 3'd2,
        read_hit    = 3'd3,
        read_victim = 3'd4,
        write_back  = 3'd5,
        fetch       = 3'd6,
        refill      = 3'd7
    } ctrl_state_t;

    // new bits where mask is set, old bits elsewhere
    function automatic word_t merge_word(word_t old_word, word_t new_word, word_t mask);
        return (new_word & mask) | (old_word & ~mask);
    endfunction

endpackage
